// ==== verilog/ringPkg.sv ====
// ring bus definitions
// slot layout, opcodes and response statuses, the tile's address
// regions and memory sizes, and the host-side command and response
package ringPkg;

	// one ring slot, 208 bits wide
	typedef struct packed
	{
		logic [15:0]	seq;	// origin node id in 15:8, tag in 7:0
		logic [15:0]	opm;	// opcode in 7:0
		logic [47:0]	addr;	// byte address
		logic [127:0]	data;	// one block
	} ringSlotT;

	// opm[7:0] opcodes
	localparam logic [7:0]	opmIdle	= 8'h00;
	localparam logic [7:0]	opmLdx	= 8'h11;	// block load
	localparam logic [7:0]	opmStx	= 8'h12;	// block store
	localparam logic [7:0]	opmOkLd	= 8'h40;	// load done
	localparam logic [7:0]	opmOkSt	= 8'h50;	// store done

	// status in opm[3:0] of a response
	localparam logic [3:0]	statOk		= 4'h0;
	localparam logic [3:0]	statBadAddr	= 4'hB;

	// where an address lands in the tile
	typedef enum logic [2:0]
	{
		regRom,
		regRam,
		regZero,
		regNop,
		regRts,
		regBad,
		regOther	// not ours, tile passes it on
	} regionT;

	// memory sizes in 128-bit blocks
	localparam int	romBlocks	= 32;
	localparam int	romIxW		= 5;
	localparam int	ramBlocks	= 64;
	localparam int	ramIxW		= 6;

	// fill page patterns
	localparam logic [127:0]	nopFill	= {8{16'h3000}};
	localparam logic [127:0]	rtsFill	= {8{16'h3010}};

	// requester node id on the ring
	localparam logic [7:0]	requesterId	= 8'h01;

	// command from the host into the requester
	typedef struct packed
	{
		logic			store;	// 1 for Stx, 0 for Ldx
		logic [47:0]	addr;
		logic [127:0]	data;	// store data
	} hostCmdT;

	// response from the requester back to the host
	typedef struct packed
	{
		logic [3:0]		status;
		logic [7:0]		tag;
		logic [127:0]	data;
	} hostRspT;

endpackage

// ==== verilog/tileAddrDecode.sv ====
// tile address decoder
// sorts a ring address into ROM, SRAM, one of the fill pages,
// a bad address or someone else's space, and gives the block indexes
`timescale 1ns/10ps

module tileAddrDecode
(
	input  logic [47:0]					addr,
	output ringPkg::regionT				region,
	output logic [ringPkg::romIxW-1:0]	romIx,
	output logic [ringPkg::ramIxW-1:0]	ramIx
);

	logic	low256k;	// bits 31:18 clear
	logic	badLow;		// below 16M but past the tile
	logic	badHigh;	// top two address bits set

	assign low256k	= (addr[31:18] == 14'h0000);
	assign badLow	= (addr[31:24] == 8'h00) && !low256k;
	assign badHigh	= (addr[31:30] != 2'b00);

	// both memories alias inside their windows
	assign romIx = addr[8:4];
	assign ramIx = addr[9:4];

	always_comb
	begin
		region = ringPkg::regOther;
		if (low256k)
		begin
			// unmapped holes in the low 64K read as zero
			region = ringPkg::regZero;
			if (addr[17:15] == 3'b000)
				region = ringPkg::regRom;	// 0000..7FFF
			else if (addr[17:13] == 5'b00110)
				region = ringPkg::regRam;	// C000..DFFF
			else if (addr[17:16] == 2'b10)
				region = ringPkg::regNop;
			else if (addr[17:16] == 2'b11)
				region = ringPkg::regRts;
		end
		else if (badLow || badHigh)
		begin
			region = ringPkg::regBad;
		end
	end

endmodule

// ==== verilog/tileMemNode.sv ====
// ROM / SRAM tile node
// two-stage ring stop: registers each passing slot, answers
// loads and stores aimed at the tile and passes the rest on.
// ROM comes from a hex image, SRAM holds 64 blocks of 128 bits
`timescale 1ns/10ps

module tileMemNode
(
	input  logic				clock,
	input  logic				arstN,
	input  ringPkg::ringSlotT	slotIn,
	output ringPkg::ringSlotT	slotOut
);

	logic [127:0]	romMem [ringPkg::romBlocks];
	logic [127:0]	ramMem [ringPkg::ramBlocks];

	ringPkg::regionT				inRegion;
	logic [ringPkg::romIxW-1:0]		inRomIx;
	logic [ringPkg::ramIxW-1:0]		inRamIx;
	logic							inStx;
	logic							ramWrite;

	ringPkg::ringSlotT	s1Slot;		// stage 1 slot
	ringPkg::regionT	s1Region;
	logic [127:0]		s1RomData;	// block read at stage 1
	logic [127:0]		s1RamData;	// old block for stores

	logic				s1IsLdx;
	logic				s1IsStx;
	logic				s1Answer;
	logic [3:0]			rspStatus;
	logic [127:0]		rspData;
	ringPkg::ringSlotT	nextOut;

	tileAddrDecode i_decode
	(
		.addr	(slotIn.addr),
		.region	(inRegion),
		.romIx	(inRomIx),
		.ramIx	(inRamIx)
	);

	initial
	begin
		$readmemh("romImage.hex", romMem);
	end

	assign inStx	= (slotIn.opm[7:0] == ringPkg::opmStx);
	assign ramWrite	= inStx && (inRegion == ringPkg::regRam);

	// memories and read data, no reset
	always_ff @(posedge clock)
	begin
		s1RomData <= romMem[inRomIx];
		s1RamData <= ramMem[inRamIx];	// sees the block before this write
		if (ramWrite)
			ramMem[inRamIx] <= slotIn.data;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			s1Slot		<= '0;
			s1Region	<= ringPkg::regOther;
			slotOut		<= '0;
		end
		else
		begin
			s1Slot		<= slotIn;
			s1Region	<= inRegion;
			slotOut		<= nextOut;
		end
	end

	assign s1IsLdx	= (s1Slot.opm[7:0] == ringPkg::opmLdx);
	assign s1IsStx	= (s1Slot.opm[7:0] == ringPkg::opmStx);
	assign s1Answer	= (s1IsLdx || s1IsStx) && (s1Region != ringPkg::regOther);

	assign rspStatus = (s1Region == ringPkg::regBad) ?
		ringPkg::statBadAddr : ringPkg::statOk;

	always_comb
	begin
		rspData = '0;
		if (s1IsStx)
		begin
			// stores hand back what SRAM held before
			if (s1Region == ringPkg::regRam)
				rspData = s1RamData;
		end
		else
		begin
			case (s1Region)
				ringPkg::regRom:	rspData = s1RomData;
				ringPkg::regRam:	rspData = s1RamData;
				ringPkg::regNop:	rspData = ringPkg::nopFill;
				ringPkg::regRts:	rspData = ringPkg::rtsFill;
				default:			rspData = '0;	// zero page and bad
			endcase
		end
	end

	// stage 2, answer or pass through
	always_comb
	begin
		nextOut = s1Slot;
		if (s1Answer)
		begin
			nextOut.opm[7:0]	= s1IsStx ? ringPkg::opmOkSt : ringPkg::opmOkLd;
			nextOut.opm[3:0]	= rspStatus;
			nextOut.data		= rspData;
		end
	end

endmodule

// ==== verilog/ringRequester.sv ====
// host-side ring requester
// drops host load/store commands into free ring slots with a
// running tag, and pulls its own responses back off the ring
`timescale 1ns/10ps

module ringRequester
(
	input  logic				clock,
	input  logic				arstN,
	input  logic				cmdValid,
	output logic				cmdReady,
	input  ringPkg::hostCmdT	cmdIn,
	output logic				rspValid,
	output ringPkg::hostRspT	rspOut,
	input  ringPkg::ringSlotT	slotIn,
	output ringPkg::ringSlotT	slotOut
);

	logic				running;	// set on the first edge out of reset
	logic [7:0]			tagCount;
	logic				isResp;
	logic				isMine;
	logic				isIdle;
	logic				slotFree;
	logic				cmdTake;
	ringPkg::ringSlotT	cmdSlot;
	ringPkg::ringSlotT	nextSlot;

	// a response for us, by opcode class and origin node
	assign isResp	= (slotIn.opm[7:6] == 2'b01);
	assign isMine	= isResp && (slotIn.seq[15:8] == ringPkg::requesterId);
	assign isIdle	= (slotIn.opm[7:0] == ringPkg::opmIdle);
	assign slotFree	= isMine || isIdle;	// consumed slots count as free

	assign cmdReady	= running && slotFree;
	assign cmdTake	= cmdValid && cmdReady;

	always_comb
	begin
		cmdSlot				= '0;
		cmdSlot.seq			= {ringPkg::requesterId, tagCount};
		cmdSlot.opm[7:0]	= cmdIn.store ? ringPkg::opmStx : ringPkg::opmLdx;
		cmdSlot.addr		= cmdIn.addr;
		if (cmdIn.store)
			cmdSlot.data	= cmdIn.data;
	end

	always_comb
	begin
		nextSlot = slotIn;
		if (cmdTake)
			nextSlot = cmdSlot;
		else if (isMine)
			nextSlot = '0;	// leaves as idle
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			running		<= 1'b0;
			tagCount	<= 8'h00;
			rspValid	<= 1'b0;
			slotOut		<= '0;
		end
		else
		begin
			running		<= 1'b1;
			rspValid	<= isMine;
			slotOut		<= nextSlot;
			if (cmdTake)
				tagCount <= tagCount + 8'h01;
		end
	end

	// response payload, valid with rspValid
	always_ff @(posedge clock)
	begin
		if (isMine)
		begin
			rspOut.status	<= slotIn.opm[3:0];
			rspOut.tag		<= slotIn.seq[7:0];
			rspOut.data		<= slotIn.data;
		end
	end

endmodule

// ==== verilog/ringTop.sv ====
// ring top level
// closes a single slot ring through the host requester and
// the ROM/SRAM tile, giving a fixed four cycle command latency
`timescale 1ns/10ps

module ringTop
(
	input  logic				clock,
	input  logic				arstN,
	input  logic				cmdValid,
	output logic				cmdReady,
	input  ringPkg::hostCmdT	cmdIn,
	output logic				rspValid,
	output ringPkg::hostRspT	rspOut
);

	ringPkg::ringSlotT	slotToTile;	// requester to tile
	ringPkg::ringSlotT	slotToHost;	// tile back to requester

	ringRequester i_requester
	(
		.clock		(clock),
		.arstN		(arstN),
		.cmdValid	(cmdValid),
		.cmdReady	(cmdReady),
		.cmdIn		(cmdIn),
		.rspValid	(rspValid),
		.rspOut		(rspOut),
		.slotIn		(slotToHost),
		.slotOut	(slotToTile)
	);

	tileMemNode i_memNode
	(
		.clock		(clock),
		.arstN		(arstN),
		.slotIn		(slotToTile),
		.slotOut	(slotToHost)
	);

endmodule

// ==== bench/ringTbCheck.svh ====
// ring testbench checks and tile model
// compare tasks for the response and the handshake bits, a
// reference model of the tile's memory map, and the watchdog
`ifndef RING_TB_CHECK_SVH
`define RING_TB_CHECK_SVH

logic [127:0]	romModel [ringPkg::romBlocks];
logic [127:0]	ramModel [ringPkg::ramBlocks];
bit				ramKnown [ringPkg::ramBlocks];	// block written at least once

task automatic checkBit(input string name, input logic got, input logic exp);
	if (got !== exp)
		failRun($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
endtask

task automatic checkRsp(input string name, input ringPkg::hostRspT got,
	input ringPkg::hostRspT exp, input logic withData);
	logic	dataBad;
	dataBad = withData && (got.data !== exp.data);	// old SRAM block may be unknown
	if ((got.status !== exp.status) || (got.tag !== exp.tag) || dataBad)
		failRun($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
endtask

// memory map of the tile
function automatic ringPkg::regionT regionOf(input logic [47:0] addr);
	if (addr[31:18] != 14'h0000)
		return ((addr[31:24] == 8'h00) || (addr[31:30] != 2'b00)) ?
			ringPkg::regBad : ringPkg::regOther;
	if (addr[17:15] == 3'b000)
		return ringPkg::regRom;
	if (addr[17:13] == 5'b00110)
		return ringPkg::regRam;
	if (addr[17:16] == 2'b10)
		return ringPkg::regNop;
	if (addr[17:16] == 2'b11)
		return ringPkg::regRts;
	return ringPkg::regZero;	// zero page and the holes below 64K
endfunction

task automatic predictResponse(input stepT s, input logic [127:0] wrData,
	output ringPkg::hostRspT exp, output logic withData);
	logic [ringPkg::ramIxW-1:0]	ramIx;
	ramIx		= s.addr[9:4];
	exp.status	= s.expStat;
	exp.tag		= 8'h00;
	exp.data	= '0;
	withData	= 1'b1;
	case (regionOf(s.addr))
		ringPkg::regRom:	exp.data = s.store ? '0 : romModel[s.addr[8:4]];
		ringPkg::regNop:	exp.data = s.store ? '0 : ringPkg::nopFill;
		ringPkg::regRts:	exp.data = s.store ? '0 : ringPkg::rtsFill;
		ringPkg::regRam:
		begin
			exp.data	= ramModel[ramIx];	// loads and stores both see the current block
			withData	= ramKnown[ramIx];
			if (s.store)
			begin
				ramModel[ramIx] = wrData;
				ramKnown[ramIx] = 1'b1;
			end
		end
		ringPkg::regOther:	failRun("stimulus table holds an address the tile does not serve");
		default:			exp.data = '0;	// zero page and bad addresses
	endcase
endtask

task automatic runWatchdog(input int cycles);
	repeat (cycles) @(posedge clock);
	failRun($sformatf("watchdog: responses stopped arriving within %0d cycles", cycles));
endtask

`endif

// ==== bench/ringTb.sv ====
// ring tile testbench
// drives a table of loads and stores into the requester, predicts
// each response from a model of the tile and checks tag, status,
// data and the fixed four cycle latency
`timescale 1ns/10ps

module ringTb;

	typedef struct packed
	{
		logic			store;
		logic [47:0]	addr;
		logic [127:0]	data;
		logic			rnd;		// replace data by random
		int				gap;		// idle cycles after the command
		logic [3:0]		expStat;
	} stepT;

	typedef struct packed
	{
		ringPkg::hostRspT	rsp;
		logic				withData;
		int					due;	// cycle in which rspValid is seen
	} pendingT;

	logic				clock;
	logic				arstN;
	logic				cmdValid;
	logic				cmdReady;
	ringPkg::hostCmdT	cmdIn;
	logic				rspValid;
	ringPkg::hostRspT	rspOut;

	stepT		steps [$];
	pendingT	expected [$];
	int			cycleCount = 0;
	logic [7:0]	nextTag = 8'h00;
	logic		tableReady = 1'b0;
	logic		monitorOn = 1'b0;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "ringTbCheck.svh"

	ringTop i_dut
	(
		.clock		(clock),
		.arstN		(arstN),
		.cmdValid	(cmdValid),
		.cmdReady	(cmdReady),
		.cmdIn		(cmdIn),
		.rspValid	(rspValid),
		.rspOut		(rspOut)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock)
		cycleCount <= cycleCount + 1;

	task automatic addRow(input logic store, input logic [47:0] addr,
		input logic [127:0] data, input logic rnd, input int gap, input logic [3:0] expStat);
		stepT	row;
		row.store	= store;
		row.addr	= addr;
		row.data	= data;
		row.rnd		= rnd;
		row.gap		= gap;
		row.expStat	= expStat;
		steps.push_back(row);
	endtask

	// store flag, address, data, random, gap, status
	task automatic fillTable;
		addRow(1'b0, 48'h0000_0000_0000, '0, 1'b0, 1, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_0130, '0, 1'b0, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_7F30, '0, 1'b0, 0, ringPkg::statOk);	// alias of 0130
		addRow(1'b0, 48'h0000_0000_01F0, '0, 1'b0, 2, ringPkg::statOk);
		addRow(1'b1, 48'h0000_0000_C040, '0, 1'b1, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_C040, '0, 1'b0, 0, ringPkg::statOk);	// right behind the store
		addRow(1'b1, 48'h0000_0000_C040, '0, 1'b1, 1, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_C440, '0, 1'b0, 0, ringPkg::statOk);	// SRAM alias
		addRow(1'b1, 48'h0000_0000_DFF0, '0, 1'b1, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_DFF0, '0, 1'b0, 0, ringPkg::statOk);
		addRow(1'b1, 48'h0000_0000_C100,
			128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210, 1'b0, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_C100, '0, 1'b0, 3, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0001_0000, '0, 1'b0, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0002_0000, '0, 1'b0, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0003_FFF0, '0, 1'b0, 0, ringPkg::statOk);
		addRow(1'b1, 48'h0000_0000_0130,
			128'hDEAD_BEEF_DEAD_BEEF_DEAD_BEEF_DEAD_BEEF, 1'b0, 1, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_0130, '0, 1'b0, 0, ringPkg::statOk);	// ROM unchanged
		addRow(1'b1, 48'h0000_0001_8000, '0, 1'b1, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0004_0000, '0, 1'b0, 0, ringPkg::statBadAddr);
		addRow(1'b1, 48'h0000_4000_0000, '0, 1'b1, 0, ringPkg::statBadAddr);
		addRow(1'b0, 48'h0000_00FF_FFF0, '0, 1'b0, 0, ringPkg::statBadAddr);
		addRow(1'b0, 48'h0000_C000_0000, '0, 1'b0, 2, ringPkg::statBadAddr);
		addRow(1'b0, 48'h0000_0000_0050, '0, 1'b0, 0, ringPkg::statOk);
		addRow(1'b1, 48'h0000_0000_C2A0, '0, 1'b1, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_C2A0, '0, 1'b0, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0002_ABC0, '0, 1'b0, 0, ringPkg::statOk);
		addRow(1'b0, 48'h0000_0000_C440, '0, 1'b0, 0, ringPkg::statOk);
	endtask

	initial
	begin
		logic [127:0]		wrData;
		ringPkg::hostRspT	expRsp;
		logic				withData;
		stepT				s;
		pendingT			pend;
		void'($urandom(32'h4386_8905));
		arstN		= 1'b0;
		cmdValid	= 1'b0;
		cmdIn		= '0;
		$readmemh("romImage.hex", romModel);
		fillTable();
		tableReady	= 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		checkBit("cmdReady", cmdReady, 1'b0);
		checkBit("rspValid", rspValid, 1'b0);
		arstN = 1'b1;
		@(posedge clock);
		monitorOn = 1'b1;
		repeat (3) @(negedge clock);	// idle ring before the first command
		for (int i = 0; i < steps.size(); i++)
		begin
			s		= steps[i];
			wrData	= s.rnd ? {$urandom(), $urandom(), $urandom(), $urandom()} : s.data;
			predictResponse(s, wrData, expRsp, withData);
			expRsp.tag		= nextTag;
			nextTag			= nextTag + 8'h01;
			pend.rsp		= expRsp;
			pend.withData	= withData;
			pend.due		= cycleCount + 4;
			expected.push_back(pend);
			cmdIn.store	= s.store;
			cmdIn.addr	= s.addr;
			cmdIn.data	= s.store ? wrData : '0;
			cmdValid	= 1'b1;
			@(negedge clock);
			cmdValid = 1'b0;
			repeat (s.gap) @(negedge clock);
		end
		while (expected.size() != 0)
			@(negedge clock);
		repeat (4) @(negedge clock);	// no stray responses
		$display("TEST PASSED");
		$finish;
	end

	// handshake and response checks at every falling edge
	initial
	begin
		logic		expValid;
		pendingT	front;
		wait (monitorOn);
		forever
		begin
			@(negedge clock);
			expValid = (expected.size() != 0) && (expected[0].due == cycleCount);
			checkBit("cmdReady", cmdReady, 1'b1);
			checkBit("rspValid", rspValid, expValid);
			if (rspValid)
			begin
				front = expected.pop_front();
				checkRsp("rspOut", rspOut, front.rsp, front.withData);
			end
		end
	end

	initial
	begin
		wait (tableReady);
		runWatchdog(steps.size() * 10 + 50);
	end

endmodule

// ==== src.f ====
+incdir+bench
verilog/ringPkg.sv
verilog/tileAddrDecode.sv
verilog/tileMemNode.sv
verilog/ringRequester.sv
verilog/ringTop.sv
bench/ringTb.sv

// ==== Makefile ====
# Verilator build and run of the ring tile testbench

sim:
	verilator --binary -j 0 --timescale 1ns/10ps --top-module ringTb -f src.f
	out=$$(./obj_dir/VringTb); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== romImage.hex ====
// tile ROM image, one 128-bit block per line, block 0 first
// each 32-bit word holds A5, block index, word index, inverted block index
A50003FFA50002FFA50001FFA50000FF
A50103FEA50102FEA50101FEA50100FE
A50203FDA50202FDA50201FDA50200FD
A50303FCA50302FCA50301FCA50300FC
A50403FBA50402FBA50401FBA50400FB
A50503FAA50502FAA50501FAA50500FA
A50603F9A50602F9A50601F9A50600F9
A50703F8A50702F8A50701F8A50700F8
A50803F7A50802F7A50801F7A50800F7
A50903F6A50902F6A50901F6A50900F6
A50A03F5A50A02F5A50A01F5A50A00F5
A50B03F4A50B02F4A50B01F4A50B00F4
A50C03F3A50C02F3A50C01F3A50C00F3
A50D03F2A50D02F2A50D01F2A50D00F2
A50E03F1A50E02F1A50E01F1A50E00F1
A50F03F0A50F02F0A50F01F0A50F00F0
A51003EFA51002EFA51001EFA51000EF
A51103EEA51102EEA51101EEA51100EE
A51203EDA51202EDA51201EDA51200ED
A51303ECA51302ECA51301ECA51300EC
A51403EBA51402EBA51401EBA51400EB
A51503EAA51502EAA51501EAA51500EA
A51603E9A51602E9A51601E9A51600E9
A51703E8A51702E8A51701E8A51700E8
A51803E7A51802E7A51801E7A51800E7
A51903E6A51902E6A51901E6A51900E6
A51A03E5A51A02E5A51A01E5A51A00E5
A51B03E4A51B02E4A51B01E4A51B00E4
A51C03E3A51C02E3A51C01E3A51C00E3
A51D03E2A51D02E2A51D01E2A51D00E2
A51E03E1A51E02E1A51E01E1A51E00E1
A51F03E0A51F02E0A51F01E0A51F00E0
